// File: rtl/decode_pkg.sv
// Decode stage package with RV32I field widths, opcodes, unit indices and stage structs
`default_nettype none

package decode_pkg;

    ////////////////////////////////////////////////////////////
    // Widths
    localparam int XLEN = 32;

    typedef logic [31:0]     instr_t;
    typedef logic [XLEN-1:0] data_t;
    typedef logic [4:0]      reg_addr_t;
    typedef logic [2:0]      fn3_t;
    typedef logic [4:0]      opcode_trim_t;   // opcode[6:2]

    ////////////////////////////////////////////////////////////
    // Trimmed opcodes
    localparam opcode_trim_t LUI_T       = 5'b01101;
    localparam opcode_trim_t AUIPC_T     = 5'b00101;
    localparam opcode_trim_t JAL_T       = 5'b11011;
    localparam opcode_trim_t JALR_T      = 5'b11001;
    localparam opcode_trim_t BRANCH_T    = 5'b11000;
    localparam opcode_trim_t LOAD_T      = 5'b00000;
    localparam opcode_trim_t STORE_T     = 5'b01000;
    localparam opcode_trim_t ARITH_T     = 5'b01100;
    localparam opcode_trim_t ARITH_IMM_T = 5'b00100;
    // Units not present in this core
    localparam opcode_trim_t AMO_T       = 5'b01011;
    localparam opcode_trim_t FENCE_T     = 5'b00011;
    localparam opcode_trim_t SYSTEM_T    = 5'b11100;

    ////////////////////////////////////////////////////////////
    // Execution units
    localparam int NUM_UNITS = 3;
    localparam int ALU_ID    = 0;
    localparam int BRANCH_ID = 1;
    localparam int LS_ID     = 2;

    typedef logic [NUM_UNITS-1:0] unit_vec_t;   // One bit per unit

    // ALU operation and logic path selects
    localparam logic [1:0] ALU_ADD_SUB   = 2'b00;
    localparam logic [1:0] ALU_SLT       = 2'b01;
    localparam logic [1:0] ALU_LSHIFT    = 2'b10;
    localparam logic [1:0] ALU_RSHIFT    = 2'b11;

    localparam logic [1:0] ALU_LOGIC_ADD = 2'b00;
    localparam logic [1:0] ALU_LOGIC_XOR = 2'b01;
    localparam logic [1:0] ALU_LOGIC_OR  = 2'b10;
    localparam logic [1:0] ALU_LOGIC_AND = 2'b11;

    // Integer funct3 encodings
    localparam fn3_t ADD_SUB_fn3 = 3'b000;
    localparam fn3_t SLL_fn3     = 3'b001;
    localparam fn3_t SLT_fn3     = 3'b010;
    localparam fn3_t SLTU_fn3    = 3'b011;
    localparam fn3_t XOR_fn3     = 3'b100;
    localparam fn3_t SRA_fn3     = 3'b101;   // Also SRL
    localparam fn3_t OR_fn3      = 3'b110;
    localparam fn3_t AND_fn3     = 3'b111;

    ////////////////////////////////////////////////////////////
    // Stage structs
    typedef struct packed {
        data_t  pc;
        instr_t instruction;
        logic   uses_rs1;
        logic   uses_rs2;
        logic   uses_rd;
        logic   rd_zero;
    } ib_entry_t;

    typedef struct packed {
        unit_vec_t request;
        logic      is_load;
        logic      is_store;
        logic      illegal;
    } instr_class_t;

    typedef struct packed {
        logic [XLEN:0] in1;        // Extension bit above data
        logic [XLEN:0] in2;
        logic          subtract;
        logic [1:0]    op;
        logic [1:0]    logic_op;
    } alu_inputs_t;

    typedef struct packed {
        data_t       virtual_address;
        data_t       rs2;
        logic [11:0] offset;
        fn3_t        fn3;
        logic        load;
        logic        store;
        logic        load_store_forward;
    } ls_inputs_t;

endpackage

`default_nettype wire

// File: rtl/unit_classifier.sv
// Instruction classifier mapping the opcode to a unit request and flagging illegal encodings
`timescale 1ns/1ps
`default_nettype none

module unit_classifier
    import decode_pkg::*;
(
    input  ib_entry_t    ib,
    output instr_class_t instr_class
);

    opcode_trim_t opcode_trim;
    logic         full_width;     // Low opcode bits must be 2'b11
    logic         mul_div_op;
    logic         absent_unit_op;

    assign opcode_trim = ib.instruction[6:2];
    assign full_width  = (ib.instruction[1:0] == 2'b11);
    assign mul_div_op  = ib.instruction[25];

    // Opcodes of units this core does not have
    assign absent_unit_op = opcode_trim inside {AMO_T, FENCE_T, SYSTEM_T};

    assign instr_class.request[BRANCH_ID] = full_width &&
        (opcode_trim inside {BRANCH_T, JAL_T, JALR_T});

    assign instr_class.request[ALU_ID] = full_width &&
        ((opcode_trim inside {LUI_T, AUIPC_T, ARITH_IMM_T}) ||
         ((opcode_trim == ARITH_T) && !mul_div_op));

    assign instr_class.request[LS_ID] = full_width &&
        (opcode_trim inside {LOAD_T, STORE_T});

    assign instr_class.is_load  = full_width && (opcode_trim == LOAD_T);
    assign instr_class.is_store = full_width && (opcode_trim == STORE_T);

    // Anything without a unit is illegal, M extension included
    assign instr_class.illegal = absent_unit_op || !(|instr_class.request);

endmodule

`default_nettype wire

// File: rtl/load_forward_tracker.sv
// Load-to-store forward tracker remembering the last load destination
`timescale 1ns/1ps
`default_nettype none

module load_forward_tracker
    import decode_pkg::*;
(
    input  logic         clk,
    input  logic         rst,
    input  ib_entry_t    ib,
    input  instr_class_t instr_class,
    input  unit_vec_t    unit_issue,
    output logic         load_store_forward
);

    reg_addr_t rd_addr;
    reg_addr_t rs2_addr;
    reg_addr_t load_rd;
    logic      last_was_load;
    logic      issued;
    logic      load_issued;

    assign rd_addr     = ib.instruction[11:7];
    assign rs2_addr    = ib.instruction[24:20];
    assign issued      = |unit_issue;
    assign load_issued = unit_issue[LS_ID] & instr_class.is_load;

    always_ff @(posedge clk) begin
        if (load_issued)
            load_rd <= rd_addr;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            last_was_load <= 1'b0;
        end else if (issued) begin
            if (load_issued)
                last_was_load <= 1'b1;
            else if (ib.uses_rd && (rd_addr == load_rd))
                last_was_load <= 1'b0;   // Load result overwritten
        end
    end

    assign load_store_forward = instr_class.is_store && last_was_load && (rs2_addr == load_rd);

endmodule

`default_nettype wire

// File: rtl/issue_control.sv
// Issue control combining unit requests, readiness, operand hazards and forwarding
`timescale 1ns/1ps
`default_nettype none

module issue_control
    import decode_pkg::*;
(
    input  logic         instr_valid,
    input  logic         issue_hold,
    input  ib_entry_t    ib,
    input  instr_class_t instr_class,
    input  unit_vec_t    unit_ready,
    input  logic         rs1_conflict,
    input  logic         rs2_conflict,
    input  logic         load_store_forward,
    output unit_vec_t    unit_issue,
    output logic         instr_pop
);

    logic      issue_valid;
    logic      rs1_blocked;
    logic      rs2_blocked;
    logic      operands_ready;
    logic      ls_operands_ready;
    unit_vec_t issue_ready;

    assign issue_valid = instr_valid & ~issue_hold;

    // Only operands the instruction reads can stall it
    assign rs1_blocked = rs1_conflict & ib.uses_rs1;
    assign rs2_blocked = rs2_conflict & ib.uses_rs2;

    assign operands_ready    = ~rs1_blocked & ~rs2_blocked;
    assign ls_operands_ready = ~rs1_blocked & ~(rs2_blocked & ~load_store_forward);

    ////////////////////////////////////////////////////////////
    // Unit readiness
    assign issue_ready[ALU_ID]    = instr_class.request[ALU_ID] & unit_ready[ALU_ID];
    assign issue_ready[BRANCH_ID] = instr_class.request[BRANCH_ID] &
                                    (unit_ready[BRANCH_ID] | ~ib.uses_rd);
    assign issue_ready[LS_ID]     = instr_class.request[LS_ID] & unit_ready[LS_ID];

    assign unit_issue[ALU_ID]    = issue_valid & operands_ready & issue_ready[ALU_ID];
    assign unit_issue[BRANCH_ID] = issue_valid & operands_ready & issue_ready[BRANCH_ID];
    assign unit_issue[LS_ID]     = issue_valid & ls_operands_ready & issue_ready[LS_ID];

    assign instr_pop = |unit_issue;   // Buffer advances on any issue

endmodule

`default_nettype wire

// File: rtl/alu_operand_builder.sv
// ALU operand builder registering operands and operation selects on ALU issue
`timescale 1ns/1ps
`default_nettype none

module alu_operand_builder
    import decode_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  ib_entry_t   ib,
    input  data_t       rs1_data,
    input  data_t       rs2_data,
    input  logic        alu_issue,
    output logic        alu_start,
    output alu_inputs_t alu_inputs
);

    opcode_trim_t opcode_trim;
    fn3_t         fn3;
    logic         is_upper;      // LUI or AUIPC
    data_t        op1;
    data_t        op2;
    logic         alu_sub;
    logic [1:0]   alu_op;
    logic [1:0]   alu_logic_op;

    assign opcode_trim = ib.instruction[6:2];
    assign fn3         = ib.instruction[14:12];
    assign is_upper    = opcode_trim inside {LUI_T, AUIPC_T};

    ////////////////////////////////////////////////////////////
    // Operand selection
    always_comb begin
        if (opcode_trim == LUI_T)
            op1 = '0;
        else if (opcode_trim == AUIPC_T)
            op1 = ib.pc;
        else
            op1 = rs1_data;
    end

    always_comb begin
        if (is_upper)
            op2 = {ib.instruction[31:12], 12'b0};
        else if (opcode_trim == ARITH_IMM_T)
            op2 = data_t'(signed'(ib.instruction[31:20]));
        else
            op2 = rs2_data;
    end

    // Sub for SUB and SLT[U][I]
    assign alu_sub = !is_upper && ((fn3 inside {SLT_fn3, SLTU_fn3}) ||
        ((fn3 == ADD_SUB_fn3) && ib.instruction[30] && (opcode_trim == ARITH_T)));

    always_comb begin
        case (fn3)
            SLT_fn3, SLTU_fn3: alu_op = ALU_SLT;
            SLL_fn3:           alu_op = ALU_LSHIFT;
            SRA_fn3:           alu_op = ALU_RSHIFT;
            default:           alu_op = ALU_ADD_SUB;   // ADD_SUB and logic ops
        endcase
    end

    always_comb begin
        case (fn3)
            XOR_fn3: alu_logic_op = ALU_LOGIC_XOR;
            OR_fn3:  alu_logic_op = ALU_LOGIC_OR;
            AND_fn3: alu_logic_op = ALU_LOGIC_AND;
            default: alu_logic_op = ALU_LOGIC_ADD;
        endcase
    end

    ////////////////////////////////////////////////////////////
    // Registered outputs
    always_ff @(posedge clk) begin
        if (alu_issue) begin
            // Unsigned compare when fn3[0] set
            alu_inputs.in1      <= {op1[XLEN-1] & ~fn3[0], op1};
            alu_inputs.in2      <= {op2[XLEN-1] & ~fn3[0], op2};
            alu_inputs.subtract <= alu_sub;
            alu_inputs.op       <= is_upper ? ALU_ADD_SUB : alu_op;
            alu_inputs.logic_op <= is_upper ? ALU_LOGIC_ADD : alu_logic_op;
        end
    end

    always_ff @(posedge clk) begin
        if (rst)
            alu_start <= 1'b0;
        else
            alu_start <= alu_issue;
    end

endmodule

`default_nettype wire

// File: rtl/ls_operand_builder.sv
// Load/store operand builder forming offset, virtual address and control fields
`timescale 1ns/1ps
`default_nettype none

module ls_operand_builder
    import decode_pkg::*;
(
    input  ib_entry_t    ib,
    input  instr_class_t instr_class,
    input  data_t        rs1_data,
    input  data_t        rs2_data,
    input  logic         rs2_conflict,
    output ls_inputs_t   ls_inputs
);

    logic [11:0] ls_offset;

    // Stores split the immediate around rd
    assign ls_offset = instr_class.is_store ?
                       {ib.instruction[31:25], ib.instruction[11:7]} :
                       ib.instruction[31:20];

    assign ls_inputs.offset          = ls_offset;
    assign ls_inputs.virtual_address = rs1_data + data_t'(signed'(ls_offset));
    assign ls_inputs.rs2             = rs2_data;
    assign ls_inputs.fn3             = ib.instruction[14:12];   // Width and sign
    assign ls_inputs.load            = instr_class.is_load;
    assign ls_inputs.store           = instr_class.is_store;

    // Store data still pending from an earlier load
    assign ls_inputs.load_store_forward = instr_class.is_store & rs2_conflict;

endmodule

`default_nettype wire

// File: rtl/decode_issue.sv
// Decode and issue stage top level for the RV32I in-order core
`timescale 1ns/1ps
`default_nettype none

module decode_issue
    import decode_pkg::*;
(
    input  logic        clk,
    input  logic        rst,

    // Instruction buffer head
    input  ib_entry_t   ib,
    input  logic        instr_valid,
    output logic        instr_pop,

    input  logic        issue_hold,
    input  unit_vec_t   unit_ready,

    // Register file
    input  data_t       rs1_data,
    input  data_t       rs2_data,
    input  logic        rs1_conflict,
    input  logic        rs2_conflict,

    output unit_vec_t   unit_issue,
    output logic        alu_start,
    output alu_inputs_t alu_inputs,
    output ls_inputs_t  ls_inputs,
    output logic        illegal_instruction
);

    instr_class_t instr_class;
    logic         load_store_forward;

    ////////////////////////////////////////////////////////////
    // Classification and hazard tracking
    unit_classifier u_unit_classifier (
        .ib          (ib),
        .instr_class (instr_class)
    );

    load_forward_tracker u_load_forward_tracker (
        .clk                (clk),
        .rst                (rst),
        .ib                 (ib),
        .instr_class        (instr_class),
        .unit_issue         (unit_issue),
        .load_store_forward (load_store_forward)
    );

    issue_control u_issue_control (
        .instr_valid        (instr_valid),
        .issue_hold         (issue_hold),
        .ib                 (ib),
        .instr_class        (instr_class),
        .unit_ready         (unit_ready),
        .rs1_conflict       (rs1_conflict),
        .rs2_conflict       (rs2_conflict),
        .load_store_forward (load_store_forward),
        .unit_issue         (unit_issue),
        .instr_pop          (instr_pop)
    );

    ////////////////////////////////////////////////////////////
    // Unit operands
    alu_operand_builder u_alu_operand_builder (
        .clk        (clk),
        .rst        (rst),
        .ib         (ib),
        .rs1_data   (rs1_data),
        .rs2_data   (rs2_data),
        .alu_issue  (unit_issue[ALU_ID]),
        .alu_start  (alu_start),
        .alu_inputs (alu_inputs)
    );

    ls_operand_builder u_ls_operand_builder (
        .ib           (ib),
        .instr_class  (instr_class),
        .rs1_data     (rs1_data),
        .rs2_data     (rs2_data),
        .rs2_conflict (rs2_conflict),
        .ls_inputs    (ls_inputs)
    );

    assign illegal_instruction = instr_class.illegal;

endmodule

`default_nettype wire

// File: tests/decode_issue_checker.sv
// Issue protocol checker bound to the decode and issue stage top level
`timescale 1ns/1ps
`default_nettype none

module decode_issue_checker
    import decode_pkg::*;
(
    input logic      clk,
    input logic      rst,
    input logic      instr_pop,
    input unit_vec_t unit_issue,
    input logic      alu_start,
    input logic      illegal_instruction
);

    ////////////////////////////////////////////////////////////
    // Handshake
    pop_matches_issue: assert property (@(posedge clk) disable iff (rst)
        instr_pop == |unit_issue)
        else $error("instr_pop differs from the OR of unit_issue");

    issue_one_hot: assert property (@(posedge clk) disable iff (rst)
        $onehot0(unit_issue))
        else $error("more than one unit issued in a cycle");

    // ALU operands arrive one cycle later
    alu_start_after_issue: assert property (@(posedge clk) disable iff (rst)
        unit_issue[ALU_ID] |=> alu_start)
        else $error("alu_start missing after an ALU issue");

    alu_start_only_after_issue: assert property (@(posedge clk) disable iff (rst)
        !unit_issue[ALU_ID] |=> !alu_start)
        else $error("alu_start without an ALU issue");

    illegal_never_pops: assert property (@(posedge clk) disable iff (rst)
        illegal_instruction |-> !instr_pop)
        else $error("illegal instruction popped");

endmodule

bind decode_issue decode_issue_checker u_issue_checker (
    .clk                 (clk),
    .rst                 (rst),
    .instr_pop           (instr_pop),
    .unit_issue          (unit_issue),
    .alu_start           (alu_start),
    .illegal_instruction (illegal_instruction)
);

`default_nettype wire

// File: tests/decode_issue_tb.sv
// Testbench for the decode and issue stage with a reference model checked by assertions
`timescale 1ns/1ps
`default_nettype none

module decode_issue_tb
    import decode_pkg::*;
();

    localparam int CLK_PERIOD   = 20;
    localparam int RESET_CYCLES = 16;
    localparam int TEST_CYCLES  = 12000;

    // RV32 major opcodes
    localparam logic [6:0] OP_LUI    = 7'b0110111;
    localparam logic [6:0] OP_AUIPC  = 7'b0010111;
    localparam logic [6:0] OP_JAL    = 7'b1101111;
    localparam logic [6:0] OP_JALR   = 7'b1100111;
    localparam logic [6:0] OP_BRANCH = 7'b1100011;
    localparam logic [6:0] OP_LOAD   = 7'b0000011;
    localparam logic [6:0] OP_STORE  = 7'b0100011;
    localparam logic [6:0] OP_IMM    = 7'b0010011;
    localparam logic [6:0] OP_REG    = 7'b0110011;
    localparam logic [6:0] OP_AMO    = 7'b0101111;
    localparam logic [6:0] OP_FENCE  = 7'b0001111;
    localparam logic [6:0] OP_SYSTEM = 7'b1110011;

    logic        clk;
    logic        rst;
    ib_entry_t   ib;
    logic        instr_valid;
    logic        issue_hold;
    unit_vec_t   unit_ready;
    data_t       rs1_data;
    data_t       rs2_data;
    logic        rs1_conflict;
    logic        rs2_conflict;
    logic        instr_pop;
    unit_vec_t   unit_issue;
    logic        alu_start;
    alu_inputs_t alu_inputs;
    ls_inputs_t  ls_inputs;
    logic        illegal_instruction;

    // Reference model state
    logic [6:0]  head_op;
    unit_vec_t   exp_req;
    unit_vec_t   exp_issue;
    logic        exp_illegal;
    logic        exp_forward;
    logic        head_load;
    logic        head_store;
    logic        rs1_ok;
    logic        rs2_ok;
    logic        can_go;
    logic        ref_last_load;
    reg_addr_t   ref_load_rd;
    alu_inputs_t exp_alu;
    logic        alu_due;        // ALU issued in the previous cycle
    logic        alu_seen;

    int error_count = 0;
    int routed_hits = 0;
    int stall_hits = 0;
    int alu_hits = 0;
    int ls_hits = 0;
    int forward_hits = 0;
    int illegal_hits = 0;

    decode_issue u_dut (
        .clk                 (clk),
        .rst                 (rst),
        .ib                  (ib),
        .instr_valid         (instr_valid),
        .instr_pop           (instr_pop),
        .issue_hold          (issue_hold),
        .unit_ready          (unit_ready),
        .rs1_data            (rs1_data),
        .rs2_data            (rs2_data),
        .rs1_conflict        (rs1_conflict),
        .rs2_conflict        (rs2_conflict),
        .unit_issue          (unit_issue),
        .alu_start           (alu_start),
        .alu_inputs          (alu_inputs),
        .ls_inputs           (ls_inputs),
        .illegal_instruction (illegal_instruction)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    task automatic report_mismatch(input string name, input logic [127:0] expected,
                                   input logic [127:0] actual);
        error_count++;
        $display("CHECK FAILED %s expected 0x%0h actual 0x%0h at %0t",
                 name, expected, actual, $time);
    endtask

    task automatic report_failure(input string what);
        error_count++;
        $display("ERROR: %s at %0t", what, $time);
    endtask

    ////////////////////////////////////////////////////////////
    // Reference rules
    function automatic unit_vec_t unit_for_opcode(input instr_t instr);
        unit_vec_t req;
        req = '0;
        case (instr[6:0])
            OP_LUI, OP_AUIPC, OP_IMM:   req[ALU_ID] = 1'b1;
            OP_REG:                     req[ALU_ID] = !instr[25];   // No M unit
            OP_BRANCH, OP_JAL, OP_JALR: req[BRANCH_ID] = 1'b1;
            OP_LOAD, OP_STORE:          req[LS_ID] = 1'b1;
            default:                    req = '0;
        endcase
        return req;
    endfunction

    function automatic logic [11:0] offset_for_instr(input instr_t instr);
        logic [11:0] offset;
        if (instr[6:0] == OP_STORE)
            offset = {instr[31:25], instr[11:7]};
        else
            offset = instr[31:20];
        return offset;
    endfunction

    function automatic data_t expected_address(input instr_t instr, input data_t base);
        logic [11:0] offset;
        offset = offset_for_instr(instr);
        return base + {{20{offset[11]}}, offset};
    endfunction

    function automatic alu_inputs_t expected_alu_inputs(input ib_entry_t e, input data_t a,
                                                        input data_t b);
        alu_inputs_t r;
        data_t       x;
        data_t       y;
        logic [6:0]  op;
        logic [2:0]  f3;
        logic        upper;
        op    = e.instruction[6:0];
        f3    = e.instruction[14:12];
        upper = (op == OP_LUI) || (op == OP_AUIPC);
        x = (op == OP_LUI) ? '0 : ((op == OP_AUIPC) ? e.pc : a);
        if (upper)
            y = {e.instruction[31:12], 12'h000};
        else if (op == OP_IMM)
            y = {{20{e.instruction[31]}}, e.instruction[31:20]};
        else
            y = b;
        r.in1 = {(f3[0] ? 1'b0 : x[31]), x};   // Zero extension for unsigned forms
        r.in2 = {(f3[0] ? 1'b0 : y[31]), y};
        r.subtract = !upper && ((f3 == 3'b010) || (f3 == 3'b011) ||
                     ((f3 == 3'b000) && (op == OP_REG) && e.instruction[30]));
        case (f3)
            3'b010, 3'b011: r.op = ALU_SLT;
            3'b001:         r.op = ALU_LSHIFT;
            3'b101:         r.op = ALU_RSHIFT;
            default:        r.op = ALU_ADD_SUB;
        endcase
        case (f3)
            3'b100:  r.logic_op = ALU_LOGIC_XOR;
            3'b110:  r.logic_op = ALU_LOGIC_OR;
            3'b111:  r.logic_op = ALU_LOGIC_AND;
            default: r.logic_op = ALU_LOGIC_ADD;
        endcase
        if (upper) begin
            r.op       = ALU_ADD_SUB;
            r.logic_op = ALU_LOGIC_ADD;
        end
        return r;
    endfunction

    assign head_op     = ib.instruction[6:0];
    assign exp_req     = unit_for_opcode(ib.instruction);
    assign exp_illegal = (exp_req == '0);
    assign head_load   = (head_op == OP_LOAD);
    assign head_store  = (head_op == OP_STORE);
    assign exp_forward = head_store && ref_last_load && (ib.instruction[24:20] == ref_load_rd);
    assign rs1_ok      = !(rs1_conflict && ib.uses_rs1);
    assign rs2_ok      = !(rs2_conflict && ib.uses_rs2);
    assign can_go      = instr_valid && !issue_hold && rs1_ok;

    always_comb begin
        exp_issue = '0;
        if (can_go && rs2_ok && exp_req[ALU_ID] && unit_ready[ALU_ID])
            exp_issue[ALU_ID] = 1'b1;
        // Branch without rd needs no result slot
        if (can_go && rs2_ok && exp_req[BRANCH_ID] && (unit_ready[BRANCH_ID] || !ib.uses_rd))
            exp_issue[BRANCH_ID] = 1'b1;
        if (can_go && (rs2_ok || exp_forward) && exp_req[LS_ID] && unit_ready[LS_ID])
            exp_issue[LS_ID] = 1'b1;
    end

    always @(posedge clk) begin
        if (rst) begin
            ref_last_load <= 1'b0;
            ref_load_rd   <= '0;
            alu_due       <= 1'b0;
            alu_seen      <= 1'b0;
        end else begin
            if (exp_issue[LS_ID] && head_load) begin
                ref_last_load <= 1'b1;
                ref_load_rd   <= ib.instruction[11:7];
            end else if (|exp_issue && ib.uses_rd && (ib.instruction[11:7] == ref_load_rd)) begin
                ref_last_load <= 1'b0;
            end
            alu_due <= exp_issue[ALU_ID];
            if (exp_issue[ALU_ID]) begin
                exp_alu  <= expected_alu_inputs(ib, rs1_data, rs2_data);
                alu_seen <= 1'b1;
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // Checks, sampled mid-cycle
    always @(negedge clk) begin
        if (!rst) begin
            assert (unit_issue === exp_issue)
                else report_mismatch("unit_issue", exp_issue, unit_issue);
            assert (instr_pop === |exp_issue)
                else report_mismatch("instr_pop", |exp_issue, instr_pop);
            assert (illegal_instruction === exp_illegal)
                else report_mismatch("illegal_instruction", exp_illegal, illegal_instruction);
            assert (alu_start === alu_due)
                else report_mismatch("alu_start", alu_due, alu_start);
            if (alu_seen) begin
                assert (alu_inputs === exp_alu)
                    else report_mismatch("alu_inputs", exp_alu, alu_inputs);
            end
            if (head_load || head_store) begin
                assert (ls_inputs.virtual_address === expected_address(ib.instruction, rs1_data))
                    else report_mismatch("ls_inputs.virtual_address",
                                         expected_address(ib.instruction, rs1_data),
                                         ls_inputs.virtual_address);
                assert (ls_inputs.offset === offset_for_instr(ib.instruction))
                    else report_mismatch("ls_inputs.offset", offset_for_instr(ib.instruction),
                                         ls_inputs.offset);
                assert (ls_inputs.rs2 === rs2_data)
                    else report_mismatch("ls_inputs.rs2", rs2_data, ls_inputs.rs2);
                assert (ls_inputs.fn3 === ib.instruction[14:12])
                    else report_mismatch("ls_inputs.fn3", ib.instruction[14:12], ls_inputs.fn3);
                assert (ls_inputs.load === head_load)
                    else report_mismatch("ls_inputs.load", head_load, ls_inputs.load);
                assert (ls_inputs.store === head_store)
                    else report_mismatch("ls_inputs.store", head_store, ls_inputs.store);
                // Store data still waiting on its register
                assert (ls_inputs.load_store_forward === (head_store && rs2_conflict))
                    else report_mismatch("ls_inputs.load_store_forward",
                                         head_store && rs2_conflict,
                                         ls_inputs.load_store_forward);
                ls_hits++;
            end
            if (alu_due)
                alu_hits++;
            if (|exp_issue && (unit_ready == '1))
                routed_hits++;
            if (instr_valid && |exp_req && (exp_issue == '0))
                stall_hits++;
            if (exp_forward && rs2_conflict && exp_issue[LS_ID])
                forward_hits++;
            if (instr_valid && exp_illegal)
                illegal_hits++;
        end
    end

    assert property (@(posedge clk) disable iff (rst) !instr_valid |-> !instr_pop)
        else report_failure("instr_pop raised without a valid entry");
    assert property (@(posedge clk) disable iff (rst) issue_hold |-> (unit_issue == '0))
        else report_failure("unit issued while issue_hold was high");
    assert property (@(posedge clk) disable iff (rst) exp_issue[ALU_ID] |=> alu_start)
        else report_failure("alu_start missing one cycle after an ALU issue");

    ////////////////////////////////////////////////////////////
    // Stimulus
    task automatic new_head_entry();
        instr_t     w;
        logic [6:0] op;
        w = $urandom();
        case ($urandom_range(15))
            0:       w[6:0] = OP_LUI;
            1:       w[6:0] = OP_AUIPC;
            2, 3:    w[6:0] = OP_IMM;
            4, 5:    w = {w[31:26], 1'b0, w[24:7], OP_REG};
            6:       w[6:0] = OP_BRANCH;
            7:       w[6:0] = OP_JAL;
            8:       w[6:0] = OP_JALR;
            9, 10:   w[6:0] = OP_LOAD;
            11, 12,
            13:      w[6:0] = OP_STORE;
            14: begin
                case ($urandom_range(4))
                    0:       w[6:0] = OP_AMO;
                    1:       w[6:0] = OP_FENCE;
                    2:       w[6:0] = OP_SYSTEM;
                    3:       w = {w[31:26], 1'b1, w[24:7], OP_REG};   // M extension
                    default: w[1:0] = 2'b00;                           // Compressed space
                endcase
            end
            default: ;   // Raw random word
        endcase
        op = w[6:0];
        if (((op == OP_JAL) || (op == OP_JALR)) && ($urandom_range(1) == 0))
            w[11:7] = 5'd0;
        // Store data from the last load
        if ((op == OP_STORE) && ref_last_load && ($urandom_range(1) == 0))
            w[24:20] = ref_load_rd;
        ib.pc          = $urandom() & 32'hffff_fffc;
        ib.instruction = w;
        ib.uses_rs1    = !((op == OP_LUI) || (op == OP_AUIPC) || (op == OP_JAL));
        ib.uses_rs2    = (op == OP_BRANCH) || (op == OP_STORE) || (op == OP_REG);
        ib.uses_rd     = !((op == OP_BRANCH) || (op == OP_STORE)) && (w[11:7] != 5'd0);
        ib.rd_zero     = (w[11:7] == 5'd0);
    endtask

    task automatic drive_controls();
        logic store_head;
        store_head  = (ib.instruction[6:0] == OP_STORE);
        instr_valid = ($urandom_range(9) != 0);
        issue_hold  = ($urandom_range(9) == 0);
        for (int i = 0; i < NUM_UNITS; i++)
            unit_ready[i] = ($urandom_range(4) != 0);
        rs1_conflict = ($urandom_range(4) == 0);
        rs2_conflict = store_head ? ($urandom_range(1) == 0) : ($urandom_range(4) == 0);
        rs1_data     = $urandom();
        rs2_data     = $urandom();
    endtask

    initial begin
        int unsigned seed_value;
        logic        popped;
        seed_value   = $urandom(68);
        clk          = 1'b0;
        rst          = 1'b1;
        ib           = '0;
        instr_valid  = 1'b0;
        issue_hold   = 1'b0;
        unit_ready   = '0;
        rs1_data     = '0;
        rs2_data     = '0;
        rs1_conflict = 1'b0;
        rs2_conflict = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        rst = 1'b0;
        new_head_entry();
        drive_controls();
        repeat (TEST_CYCLES) begin
            @(posedge clk);
            popped = |exp_issue;
            #1;
            // Illegal heads are dropped as a trap would
            if (popped || exp_illegal || ($urandom_range(3) == 0))
                new_head_entry();
            drive_controls();
        end
        @(posedge clk);
        #1;
        instr_valid = 1'b0;
        repeat (2) @(posedge clk);
        @(negedge clk);
        $display("Summary: errors=%0d routed=%0d stalled=%0d alu=%0d ls=%0d fwd=%0d illegal=%0d",
                 error_count, routed_hits, stall_hits, alu_hits, ls_hits, forward_hits,
                 illegal_hits);
        if (error_count == 0)
            $display("Simulation PASSED");
        else
            $display("Simulation FAILED");
        $finish;
    end

    // Watchdog
    initial begin
        #((RESET_CYCLES + TEST_CYCLES + 50) * CLK_PERIOD);
        $display("ERROR: watchdog timeout, the stimulus did not finish in time");
        $display("Simulation FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// File: decode_issue.f
rtl/decode_pkg.sv
rtl/unit_classifier.sv
rtl/load_forward_tracker.sv
rtl/issue_control.sv
rtl/alu_operand_builder.sv
rtl/ls_operand_builder.sv
rtl/decode_issue.sv
tests/decode_issue_checker.sv
tests/decode_issue_tb.sv

// File: Bender.yml
package:
  name: decode_issue

sources:
  # Decode and issue stage RTL, package first
  - rtl/decode_pkg.sv
  - rtl/unit_classifier.sv
  - rtl/load_forward_tracker.sv
  - rtl/issue_control.sv
  - rtl/alu_operand_builder.sv
  - rtl/ls_operand_builder.sv
  - rtl/decode_issue.sv
  - target: test
    files:
      - tests/decode_issue_checker.sv
      - tests/decode_issue_tb.sv
